// ==== common/sync_defs.svh ====
`ifndef SYNC_DEFS_SVH
`define SYNC_DEFS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////
`define PORT_NUMBER          4
`define DATA_WIDTH           64
`define CTRL_WIDTH           8
`define TIME_WIDTH           64
`define SYNC_INTERVAL_WIDTH  16   // us
`define SYNC_TIMEOUT_WIDTH   16   // in sync intervals
`define LINK_DELAY_WIDTH     32   // ns

////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////
`define CLK_PERIOD_NS        64'd8
`define CYCLES_PER_US        125
`define FRAME_WORDS          9

// receive path compensation, 690 cycles of 8 ns plus 16 ns
`define RX_FIXED_DELAY_NS    64'd5536

////////////////////////////////////////////////////////////
// sync frame constants
////////////////////////////////////////////////////////////
`define PTP_MAC_DST          48'h011B_1900_0000
`define PTP_MAC_SRC          48'h3C97_0E0F_6857
`define PTP_ETHERTYPE        16'h88F7
`define PTP_VERSION          4'h2
`define PTP_MSG_LENGTH       16'h002C
`define PTP_SOURCE_PORT_ID   80'h0000_FF05_2345_6789_ABCD
`define PTP_LOG_INTERVAL     8'h7F

`endif

// ==== common/sync_pkg.sv ====
`include "sync_defs.svh"

package sync_pkg;

	typedef logic [`DATA_WIDTH-1:0]  data_word_t;
	typedef logic [`CTRL_WIDTH-1:0]  ctrl_byte_t;
	typedef logic [`TIME_WIDTH-1:0]  time_t;
	typedef logic [`PORT_NUMBER-1:0] port_mask_t; // one bit per port

	// control byte that travels with every frame word
	typedef enum logic [`CTRL_WIDTH-1:0] {
		CTRL_SOF  = 8'hFF,
		CTRL_BODY = 8'h00,
		CTRL_EOF  = 8'h01
	} ctrl_code_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_WAIT_SOF,
		RX_BODY,
		RX_DONE
	} rx_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

endpackage

// ==== sync_rx/sync_rx_port_arb.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_rx_port_arb import sync_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       slave_mode,
	input  logic       master_mode,
	input  port_mask_t sync_rx_valid,
	input  logic       rx_busy,
	input  logic       tx_busy,
	input  logic       rx_last_word,
	output port_mask_t sync_rdy,
	output port_mask_t ingress_port
);

	port_mask_t lowest_valid;
	logic       grant_ok;

	assign lowest_valid = sync_rx_valid & (~sync_rx_valid + 1'b1); // isolate lowest set bit

	// no new grant while a frame is in flight on either side
	assign grant_ok = slave_mode && !master_mode && !rx_busy && !tx_busy &&
		(sync_rdy == '0) && (sync_rx_valid != '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync_rdy     <= '0;
			ingress_port <= '0;
		end else if (grant_ok) begin
			sync_rdy     <= lowest_valid;
			ingress_port <= lowest_valid;
		end else if (rx_last_word) begin
			sync_rdy <= '0; // ingress_port stays for relay masking
		end
	end

endmodule

// ==== sync_rx/sync_rx_parser.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_rx_parser import sync_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         master_mode,
	input  port_mask_t                   ingress_port,
	input  data_word_t                   sync_data,
	input  ctrl_byte_t                   sync_ctrl,
	input  port_mask_t                   sync_wr,
	input  logic [`LINK_DELAY_WIDTH-1:0] link_delay,
	output logic                         rx_busy,
	output logic                         rx_last_word,
	output logic                         rx_done,
	output data_word_t                   rx_header,
	output logic [47:0]                  rx_mac_dst,
	output logic [47:0]                  rx_mac_src,
	output time_t                        rx_correction,
	output logic [79:0]                  rx_origin,
	output logic [47:0]                  rx_trailer,
	output time_t                        rx_time
);

	rx_state_t  state;
	logic [3:0] word_idx;
	logic       word_valid;
	time_t      origin_lo; // origin[63:0] with the last word still on the bus

	assign word_valid   = |(sync_wr & ingress_port);
	assign rx_busy      = (state == RX_BODY) || (state == RX_DONE);
	assign rx_last_word = (state == RX_BODY) && word_valid &&
		(word_idx == 4'(`FRAME_WORDS - 1));
	assign rx_done      = (state == RX_DONE);
	assign origin_lo    = {rx_origin[63:16], sync_data[63:48]};

	////////////////////////////////////////////////////////////
	// receive FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RX_IDLE;
			word_idx <= '0;
		end else if (master_mode) begin
			state <= RX_IDLE;
		end else begin
			case (state)
				RX_IDLE: state <= RX_WAIT_SOF;
				RX_WAIT_SOF: begin
					if (word_valid && sync_ctrl == CTRL_SOF) begin
						state    <= RX_BODY;
						word_idx <= 4'd1;
					end
				end
				RX_BODY: begin
					if (word_valid) begin
						word_idx <= word_idx + 1'b1;
						if (rx_last_word)
							state <= RX_DONE;
					end
				end
				default: state <= RX_IDLE; // done lasts one cycle
			endcase
		end
	end

	// field capture
	always_ff @(posedge clk) begin
		if (state == RX_WAIT_SOF && word_valid && sync_ctrl == CTRL_SOF)
			rx_header <= sync_data;
		if (state == RX_BODY && word_valid) begin
			case (word_idx)
				4'd1: begin
					rx_mac_dst         <= sync_data[63:16];
					rx_mac_src[47:32]  <= sync_data[15:0];
				end
				4'd2: rx_mac_src[31:0] <= sync_data[63:32];
				4'd3: rx_correction[63:48] <= sync_data[15:0];
				4'd4: rx_correction[47:0]  <= sync_data[63:16];
				4'd7: rx_origin[79:16] <= sync_data;
				4'd8: begin
					rx_origin[15:0] <= sync_data[63:48];
					rx_trailer      <= sync_data[47:0];
					rx_time <= origin_lo + rx_correction + time_t'(link_delay) +
						`RX_FIXED_DELAY_NS;
				end
				default: ; // words 5 and 6 carry constants only
			endcase
		end
	end

endmodule

// ==== sync_tx/sync_tx_framer.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_tx_framer import sync_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         master_mode,
	input  logic                         sync_tick,
	input  logic                         rx_done,
	input  data_word_t                   rx_header,
	input  logic [47:0]                  rx_mac_dst,
	input  logic [47:0]                  rx_mac_src,
	input  time_t                        rx_correction,
	input  logic [79:0]                  rx_origin,
	input  logic [47:0]                  rx_trailer,
	input  logic [`LINK_DELAY_WIDTH-1:0] link_delay,
	input  time_t                        local_clk_counter,
	input  time_t                        global_time,
	output logic                         tx_busy,
	output data_word_t                   tx_data,
	output ctrl_byte_t                   tx_ctrl,
	output logic                         tx_wr
);

	localparam logic [79:0] PORT_ID = `PTP_SOURCE_PORT_ID;

	tx_state_t   state;
	logic [3:0]  word_idx;
	logic        start;
	data_word_t  hdr_q;
	logic [47:0] mac_dst_q;
	logic [47:0] mac_src_q;
	time_t       corr_q;
	logic [79:0] origin_q;
	logic [47:0] trailer_q;

	// a tick during a busy frame is lost
	assign start   = rx_done || (sync_tick && master_mode && state == TX_IDLE);
	assign tx_busy = (state == TX_SEND);
	assign tx_wr   = (state == TX_SEND);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= TX_IDLE;
			word_idx <= '0;
		end else if (start) begin
			state    <= TX_SEND;
			word_idx <= '0;
		end else if (state == TX_SEND) begin
			word_idx <= word_idx + 1'b1;
			if (word_idx == 4'(`FRAME_WORDS - 1))
				state <= TX_IDLE;
		end
	end

	////////////////////////////////////////////////////////////
	// field snapshot for master or relay
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (start) begin
			if (rx_done) begin
				hdr_q     <= rx_header;
				mac_dst_q <= rx_mac_dst;
				mac_src_q <= rx_mac_src;
				corr_q    <= rx_correction + time_t'(link_delay); // add our hop
				origin_q  <= rx_origin;
				trailer_q <= rx_trailer;
			end else begin
				hdr_q     <= local_clk_counter;
				mac_dst_q <= `PTP_MAC_DST;
				mac_src_q <= `PTP_MAC_SRC;
				corr_q    <= '0;
				origin_q  <= {16'h0, global_time};
				trailer_q <= '0;
			end
		end
	end

	// word sequencer
	always_comb begin
		case (word_idx)
			4'd0: tx_data = hdr_q;
			4'd1: tx_data = {mac_dst_q, mac_src_q[47:32]};
			4'd2: tx_data = {mac_src_q[31:0], `PTP_ETHERTYPE, 12'h000, `PTP_VERSION};
			4'd3: tx_data = {`PTP_MSG_LENGTH, 8'h00, 8'h00, 16'h0000, corr_q[63:48]};
			4'd4: tx_data = {corr_q[47:0], 16'h0000};
			4'd5: tx_data = {16'h0000, PORT_ID[79:32]};
			4'd6: tx_data = {PORT_ID[31:0], 16'h0000, 8'h00, `PTP_LOG_INTERVAL};
			4'd7: tx_data = origin_q[79:16];
			default: tx_data = {origin_q[15:0], trailer_q};
		endcase
		if (word_idx == 4'd0)
			tx_ctrl = CTRL_SOF;
		else if (word_idx == 4'(`FRAME_WORDS - 1))
			tx_ctrl = CTRL_EOF;
		else
			tx_ctrl = CTRL_BODY;
	end

endmodule

// ==== sync_tx/sync_tx_fanout.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_tx_fanout import sync_pkg::*; (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                master_mode,
	input  logic                                slave_mode,
	input  port_mask_t                          udp_rdy,
	input  port_mask_t                          ingress_port,
	input  data_word_t                          tx_data,
	input  ctrl_byte_t                          tx_ctrl,
	input  logic                                tx_wr,
	output wire  [`PORT_NUMBER*`DATA_WIDTH-1:0] udp_data,
	output wire  [`PORT_NUMBER*`CTRL_WIDTH-1:0] udp_ctrl,
	output wire  port_mask_t                    udp_wr
);

	for (genvar p = 0; p < `PORT_NUMBER; p++) begin : g_port
		data_word_t data_q;
		ctrl_byte_t ctrl_q;
		logic       wr_q;
		logic       allowed;

		// relay never goes back out of the ingress port
		assign allowed = udp_rdy[p] && (master_mode || (slave_mode && !ingress_port[p]));

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				data_q <= '0;
				ctrl_q <= '0;
				wr_q   <= 1'b0;
			end else begin
				data_q <= allowed ? tx_data : '0;
				ctrl_q <= allowed ? tx_ctrl : '0;
				wr_q   <= allowed && tx_wr; // dropped under back-pressure
			end
		end

		assign udp_data[p*`DATA_WIDTH +: `DATA_WIDTH] = data_q;
		assign udp_ctrl[p*`CTRL_WIDTH +: `CTRL_WIDTH] = ctrl_q;
		assign udp_wr[p] = wr_q;
	end

endmodule

// ==== hw/sync_time_base.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_time_base import sync_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  rx_done,
	input  time_t rx_time,
	output time_t local_clk_counter,
	output time_t global_time
);

	// free-running cycle count
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			local_clk_counter <= '0;
		else
			local_clk_counter <= local_clk_counter + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// global time in ns, loaded from a received sync frame
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			global_time <= '0;
		else if (rx_done)
			global_time <= rx_time;
		else
			global_time <= global_time + `CLK_PERIOD_NS;
	end

endmodule

// ==== hw/sync_interval_timer.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_interval_timer (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            master_mode,
	input  logic                            slave_mode,
	input  logic [`SYNC_INTERVAL_WIDTH-1:0] sync_interval,
	input  logic [`SYNC_TIMEOUT_WIDTH-1:0]  sync_timeout,
	input  logic                            rx_done,
	output logic                            sync_tick,
	output logic                            sync_state
);

	logic [6:0]                      us_cnt;
	logic                            us_wrap;
	logic [`SYNC_INTERVAL_WIDTH-1:0] interval_cnt;
	logic [`SYNC_TIMEOUT_WIDTH-1:0]  timeout_cnt;

	assign us_wrap = (us_cnt == 7'(`CYCLES_PER_US - 1));

	// 1 us prescaler and interval count
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			us_cnt       <= '0;
			interval_cnt <= '0;
			sync_tick    <= 1'b0;
		end else begin
			us_cnt <= us_wrap ? '0 : us_cnt + 1'b1;
			if (interval_cnt == sync_interval) begin
				interval_cnt <= '0;
				sync_tick    <= 1'b1;
			end else begin
				sync_tick <= 1'b0;
				if (us_wrap)
					interval_cnt <= interval_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// slave timeout, counted in sync intervals
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			timeout_cnt <= '0;
		else if (rx_done || master_mode)
			timeout_cnt <= '0;
		else if (slave_mode && sync_tick && timeout_cnt != sync_timeout)
			timeout_cnt <= timeout_cnt + 1'b1; // saturates at sync_timeout
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sync_state <= 1'b0;
		else if (master_mode)
			sync_state <= 1'b1;
		else if (slave_mode)
			sync_state <= (timeout_cnt < sync_timeout);
		else
			sync_state <= 1'b0;
	end

endmodule

// ==== hw/sync_event_ctrl.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module sync_event_ctrl import sync_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  master_mode,
	input  logic                                  slave_mode,
	input  port_mask_t                            sync_rx_valid,
	input  logic [`SYNC_INTERVAL_WIDTH-1:0]       sync_interval,
	input  logic [`SYNC_TIMEOUT_WIDTH-1:0]        sync_timeout,
	input  logic [`LINK_DELAY_WIDTH-1:0]          link_delay,
	input  data_word_t                            sync_data,
	input  ctrl_byte_t                            sync_ctrl,
	input  port_mask_t                            sync_wr,
	input  port_mask_t                            udp_rdy,
	output wire  [`PORT_NUMBER*`DATA_WIDTH-1:0]   udp_data,
	output wire  [`PORT_NUMBER*`CTRL_WIDTH-1:0]   udp_ctrl,
	output wire  port_mask_t                      udp_wr,
	output port_mask_t                            sync_rdy,
	output time_t                                 local_clk_counter,
	output time_t                                 global_time,
	output logic                                  sync_state
);

	logic        sync_tick;
	logic        rx_busy;
	logic        rx_last_word;
	logic        rx_done;
	port_mask_t  ingress_port;
	data_word_t  rx_header;
	logic [47:0] rx_mac_dst;
	logic [47:0] rx_mac_src;
	time_t       rx_correction;
	logic [79:0] rx_origin;
	logic [47:0] rx_trailer;
	time_t       rx_time;
	logic        tx_busy;
	data_word_t  tx_data;
	ctrl_byte_t  tx_ctrl;
	logic        tx_wr;

	////////////////////////////////////////////////////////////
	// receive side
	////////////////////////////////////////////////////////////
	sync_rx_port_arb i_port_arb (
		.clk, .rst, .slave_mode, .master_mode, .sync_rx_valid,
		.rx_busy, .tx_busy, .rx_last_word, .sync_rdy, .ingress_port
	);

	sync_rx_parser i_parser (
		.clk, .rst, .master_mode, .ingress_port, .sync_data, .sync_ctrl,
		.sync_wr, .link_delay, .rx_busy, .rx_last_word, .rx_done,
		.rx_header, .rx_mac_dst, .rx_mac_src, .rx_correction, .rx_origin,
		.rx_trailer, .rx_time
	);

	////////////////////////////////////////////////////////////
	// transmit side
	////////////////////////////////////////////////////////////
	sync_tx_framer i_framer (
		.clk, .rst, .master_mode, .sync_tick, .rx_done, .rx_header,
		.rx_mac_dst, .rx_mac_src, .rx_correction, .rx_origin, .rx_trailer,
		.link_delay, .local_clk_counter, .global_time,
		.tx_busy, .tx_data, .tx_ctrl, .tx_wr
	);

	sync_tx_fanout i_fanout (
		.clk, .rst, .master_mode, .slave_mode, .udp_rdy, .ingress_port,
		.tx_data, .tx_ctrl, .tx_wr, .udp_data, .udp_ctrl, .udp_wr
	);

	// time keeping and timers
	sync_time_base i_time_base (
		.clk, .rst, .rx_done, .rx_time, .local_clk_counter, .global_time
	);

	sync_interval_timer i_interval_timer (
		.clk, .rst, .master_mode, .slave_mode, .sync_interval, .sync_timeout,
		.rx_done, .sync_tick, .sync_state
	);

endmodule

// ==== tb/tb_sync_event_ctrl.sv ====
`timescale 1ns/1ps
`include "sync_defs.svh"

module tb_sync_event_ctrl import sync_pkg::*; ();

	localparam int INTERVAL_US     = 2;
	localparam int TIMEOUT_N       = 3;
	localparam int INTERVAL_CYCLES = INTERVAL_US * `CYCLES_PER_US + 2; // tick period plus slack
	localparam int WATCHDOG_CYCLES = INTERVAL_US * `CYCLES_PER_US * (TIMEOUT_N + 4) + 2000;
	localparam logic [79:0] PORT_ID = `PTP_SOURCE_PORT_ID;

	logic                                clk = 1'b0;
	logic                                rst;
	logic                                master_mode;
	logic                                slave_mode;
	port_mask_t                          sync_rx_valid;
	logic [`SYNC_INTERVAL_WIDTH-1:0]     sync_interval;
	logic [`SYNC_TIMEOUT_WIDTH-1:0]      sync_timeout;
	logic [`LINK_DELAY_WIDTH-1:0]        link_delay;
	data_word_t                          sync_data;
	ctrl_byte_t                          sync_ctrl;
	port_mask_t                          sync_wr;
	port_mask_t                          udp_rdy;
	wire  [`PORT_NUMBER*`DATA_WIDTH-1:0] udp_data;
	wire  [`PORT_NUMBER*`CTRL_WIDTH-1:0] udp_ctrl;
	wire  port_mask_t                    udp_wr;
	port_mask_t                          sync_rdy;
	time_t                               local_clk_counter;
	time_t                               global_time;
	logic                                sync_state;

	integer      seed;
	port_mask_t  exp_mask;        // ports that must carry the current frame
	int          loads_expected;
	int          seq_errors;
	int          loads_seen = 0;
	int          frames_seen = 0;
	int          mon_idx = 0;
	int          mon_errors = 0;
	logic        prev_rst = 1'b1;
	data_word_t  mon_words [0:8];
	time_t       sof_counter;
	time_t       sof_gt;
	time_t       prev_counter;
	time_t       prev_gt;
	data_word_t  f_header;
	logic [47:0] f_mac_dst;
	logic [47:0] f_mac_src;
	time_t       f_corr;
	logic [79:0] f_origin;
	logic [47:0] f_trailer;

	sync_event_ctrl i_dut (.*);

	always #50 clk = ~clk;

	function automatic data_word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// one word of the nine-word sync frame
	function automatic data_word_t layout_word(input int idx, input data_word_t hdr,
		input logic [47:0] dst, input logic [47:0] src, input time_t corr,
		input logic [79:0] origin, input logic [47:0] trailer);
		case (idx)
			0: return hdr;
			1: return {dst, src[47:32]};
			2: return {src[31:0], `PTP_ETHERTYPE, 12'h000, `PTP_VERSION};
			3: return {`PTP_MSG_LENGTH, 32'h0, corr[63:48]}; // domain, reserved, flags
			4: return {corr[47:0], 16'h0};
			5: return {16'h0, PORT_ID[79:32]};
			6: return {PORT_ID[31:0], 24'h0, `PTP_LOG_INTERVAL};
			7: return origin[79:16];
			default: return {origin[15:0], trailer};
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act, inout int errors);
		$display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
		errors++;
	endtask

	task automatic check_frame(input string name, input data_word_t hdr, input logic [47:0] dst,
		input logic [47:0] src, input time_t corr, input logic [79:0] origin,
		input logic [47:0] trailer);
		data_word_t exp;
		int         i;
		for (i = 0; i < `FRAME_WORDS; i++) begin
			exp = layout_word(i, hdr, dst, src, corr, origin, trailer);
			assert (mon_words[i] == exp)
				else report_mismatch($sformatf("%s word %0d", name, i), exp, mon_words[i],
					seq_errors);
		end
	endtask

	task automatic wait_frames(input int target, input int limit);
		int waited;
		waited = 0;
		while (frames_seen < target && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (frames_seen < target) begin
			$display("no sync frame came out on the ports within %0d cycles", limit);
			seq_errors++;
		end
	endtask

	// frame on the granted port with a stray SOF elsewhere and a gap mid-frame
	task automatic send_frame(input port_mask_t port);
		int i;
		@(posedge clk);
		#1;
		sync_wr   = 4'b0100;
		sync_ctrl = CTRL_SOF;
		sync_data = rand_word();
		for (i = 0; i < `FRAME_WORDS; i++) begin
			@(posedge clk);
			#1;
			if (i == 5) begin
				sync_wr       = '0;
				sync_rx_valid = 4'b0100; // must not move the grant
				@(posedge clk);
				#1;
			end
			sync_data = layout_word(i, f_header, f_mac_dst, f_mac_src, f_corr, f_origin, f_trailer);
			sync_ctrl = (i == 0) ? CTRL_SOF : (i == `FRAME_WORDS - 1) ? CTRL_EOF : CTRL_BODY;
			sync_wr   = port;
			if (i == `FRAME_WORDS - 1)
				sync_rx_valid = '0;
			@(negedge clk);
			assert (sync_rdy == port)
				else report_mismatch("grant held mid-frame", 64'(port), 64'(sync_rdy), seq_errors);
		end
		@(posedge clk);
		#1;
		sync_wr = '0;
		loads_expected++;
		@(negedge clk);
		assert (sync_rdy == '0)
			else report_mismatch("grant release", 64'd0, 64'(sync_rdy), seq_errors);
	endtask

	////////////////////////////////////////////////////////////
	// output monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin : output_monitor
		data_word_t ref_word;
		data_word_t exp_data;
		ctrl_byte_t exp_ctrl;
		ctrl_byte_t port_ctrl;
		int         p;
		ref_word = udp_data[`DATA_WIDTH-1:0]; // port 0 is in every expected mask
		if (mon_idx == 0)
			exp_ctrl = CTRL_SOF;
		else if (mon_idx == `FRAME_WORDS - 1)
			exp_ctrl = CTRL_EOF;
		else
			exp_ctrl = CTRL_BODY;
		if (rst) begin
			assert (udp_wr == '0)
				else report_mismatch("reset udp_wr", 64'd0, 64'(udp_wr), mon_errors);
			assert (sync_rdy == '0)
				else report_mismatch("reset sync_rdy", 64'd0, 64'(sync_rdy), mon_errors);
			assert (sync_state == 1'b0)
				else report_mismatch("reset sync_state", 64'd0, 64'(sync_state), mon_errors);
			assert (local_clk_counter == '0 && global_time == '0)
				else report_mismatch("reset time", 64'd0, local_clk_counter | global_time, mon_errors);
		end else begin
			if (!prev_rst) begin
				assert (local_clk_counter == prev_counter + 64'd1)
					else report_mismatch("local counter step", prev_counter + 64'd1,
						local_clk_counter, mon_errors);
				if (global_time != prev_gt + `CLK_PERIOD_NS && loads_seen < loads_expected) begin
					loads_seen++; // load from a received frame
				end else begin
					assert (global_time == prev_gt + `CLK_PERIOD_NS)
						else report_mismatch("global time step", prev_gt + `CLK_PERIOD_NS,
							global_time, mon_errors);
				end
			end
			if (udp_wr != '0 || mon_idx != 0) begin
				assert (udp_wr == exp_mask)
					else report_mismatch("frame port mask", 64'(exp_mask), 64'(udp_wr), mon_errors);
				assert (udp_ctrl[`CTRL_WIDTH-1:0] == exp_ctrl)
					else report_mismatch($sformatf("ctrl of word %0d", mon_idx), 64'(exp_ctrl),
						64'(udp_ctrl[`CTRL_WIDTH-1:0]), mon_errors);
				for (p = 1; p < `PORT_NUMBER; p++) begin
					exp_data  = exp_mask[p] ? ref_word : '0;
					port_ctrl = exp_mask[p] ? exp_ctrl : '0;
					assert (udp_data[p*`DATA_WIDTH +: `DATA_WIDTH] == exp_data)
						else report_mismatch($sformatf("data on port %0d", p), exp_data,
							udp_data[p*`DATA_WIDTH +: `DATA_WIDTH], mon_errors);
					assert (udp_ctrl[p*`CTRL_WIDTH +: `CTRL_WIDTH] == port_ctrl)
						else report_mismatch($sformatf("ctrl on port %0d", p), 64'(port_ctrl),
							64'(udp_ctrl[p*`CTRL_WIDTH +: `CTRL_WIDTH]), mon_errors);
				end
				if (mon_idx == 0) begin
					sof_counter = local_clk_counter;
					sof_gt      = global_time;
				end
				mon_words[mon_idx] = ref_word;
				if (mon_idx == `FRAME_WORDS - 1) begin
					mon_idx = 0;
					frames_seen++;
				end else begin
					mon_idx++;
				end
			end
		end
		prev_rst     = rst;
		prev_counter = local_clk_counter;
		prev_gt      = global_time;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, errors so far %0d", WATCHDOG_CYCLES,
			mon_errors + seq_errors);
		$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin : stimulus
		data_word_t r;
		time_t      exp_time;
		int         k;
		int         target;
		int         waited;
		seed           = 32'h943f_83a0;
		seq_errors     = 0;
		loads_expected = 0;
		rst            = 1'b1;
		master_mode    = 1'b0;
		slave_mode     = 1'b0;
		sync_rx_valid  = '0;
		sync_interval  = 16'(INTERVAL_US);
		sync_timeout   = 16'(TIMEOUT_N);
		link_delay     = '0;
		sync_data      = '0;
		sync_ctrl      = '0;
		sync_wr        = '0;
		udp_rdy        = 4'b1011;
		exp_mask       = 4'b1011;
		repeat (5) @(posedge clk);
		#1;
		rst         = 1'b0;
		master_mode = 1'b1;

		// master frames with the snapshot taken two edges before word 0 reaches a port
		for (k = 0; k < 2; k++) begin
			wait_frames(k + 1, 2 * INTERVAL_CYCLES);
			check_frame("master frame", sof_counter - 64'd2, `PTP_MAC_DST, `PTP_MAC_SRC, 64'd0,
				{16'h0, sof_gt - 64'd16}, 48'd0);
		end

		@(posedge clk);
		#1;
		master_mode = 1'b0;
		slave_mode  = 1'b1;
		udp_rdy     = 4'b1111;
		exp_mask    = 4'b1101; // no relay back out of port 1

		for (k = 0; k < 2; k++) begin
			link_delay = (k == 0) ? 32'd1500 : $random(seed);
			f_header   = rand_word();
			r          = rand_word();
			f_mac_dst  = r[47:0];
			r          = rand_word();
			f_mac_src  = r[47:0];
			f_corr     = rand_word();
			r          = rand_word();
			f_origin   = {r[15:0], rand_word()};
			f_trailer  = r[63:16];
			target     = frames_seen + 1;
			@(posedge clk);
			#1;
			sync_rx_valid = 4'b0110;
			@(posedge clk);
			@(negedge clk);
			assert (sync_rdy == 4'b0010)
				else report_mismatch("port grant", 64'd2, 64'(sync_rdy), seq_errors);
			send_frame(4'b0010);
			wait_frames(target, 40);
			exp_time = f_origin[63:0] + f_corr + time_t'(link_delay) + `RX_FIXED_DELAY_NS +
				`CLK_PERIOD_NS;
			assert (sof_gt == exp_time)
				else report_mismatch("relay time load", exp_time, sof_gt, seq_errors);
			check_frame("relay frame", f_header, f_mac_dst, f_mac_src, f_corr + time_t'(link_delay),
				f_origin, f_trailer);
		end
		assert (loads_seen == loads_expected)
			else report_mismatch("time loads", 64'(loads_expected), 64'(loads_seen), seq_errors);

		// slave timeout with no more frames
		@(negedge clk);
		assert (sync_state == 1'b1)
			else report_mismatch("sync state after frame", 64'd1, 64'(sync_state), seq_errors);
		waited = 0;
		while (sync_state && waited < (TIMEOUT_N + 1) * INTERVAL_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		assert (sync_state == 1'b0)
			else report_mismatch("sync state timeout", 64'd0, 64'(sync_state), seq_errors);

		@(posedge clk);
		#1;
		udp_rdy     = 4'b1011;
		exp_mask    = 4'b1011;
		slave_mode  = 1'b0;
		master_mode = 1'b1;
		@(posedge clk);
		@(negedge clk);
		assert (sync_state == 1'b1)
			else report_mismatch("sync state in master mode", 64'd1, 64'(sync_state), seq_errors);
		repeat (4) @(posedge clk);

		$display("summary: %0d frames, %0d monitor errors, %0d sequence errors", frames_seen,
			mon_errors, seq_errors);
		if (mon_errors + seq_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sync_event_ctrl.f ====
+incdir+common
common/sync_pkg.sv
sync_rx/sync_rx_port_arb.sv
sync_rx/sync_rx_parser.sv
sync_tx/sync_tx_framer.sv
sync_tx/sync_tx_fanout.sv
hw/sync_time_base.sv
hw/sync_interval_timer.sv
hw/sync_event_ctrl.sv
tb/tb_sync_event_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_sync_event_ctrl \
	-f sync_event_ctrl.f \
	-Mdir obj_dir -o sim_tb_sync_event_ctrl

out=$(./obj_dir/sim_tb_sync_event_ctrl)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
